//--- common/lsu_pkg.sv
package lsu_pkg;

  // ----------------------------------------------------------
  // Widths and sizes
  // ----------------------------------------------------------
  localparam int XLEN_W          = 64;
  localparam int VADDR_W         = 39;
  localparam int RNID_W          = 7;
  localparam int CMT_ID_W        = 6;
  localparam int MEM_Q_SIZE      = 8;
  localparam int DCACHE_DATA_B_W = 16;
  localparam int L1D_OFS_W       = $clog2(DCACHE_DATA_B_W);  // Byte offset in a line
  localparam int DW_OFS_W        = $clog2(XLEN_W / 8);       // Byte offset in a doubleword

  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;

  // Follows funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_B  = 2'b00,
    SIZE_H  = 2'b01,
    SIZE_W  = 2'b10,
    SIZE_DW = 2'b11
  } size_e;

  typedef enum logic {
    SIGN_U = 1'b0,
    SIGN_S = 1'b1
  } sign_e;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  // ----------------------------------------------------------
  // Port groups
  // ----------------------------------------------------------
  typedef struct packed {
    size_e size;
    sign_e sign;
    op_e   op;
  } lsu_ctrl_t;

  typedef struct packed {
    logic                valid;
    logic [31:0]         inst;
    logic [CMT_ID_W-1:0] cmt_id;
    logic                rs1_valid;
    logic [RNID_W-1:0]   rs1_rnid;
    logic                rs2_valid;
    logic [RNID_W-1:0]   rs2_rnid;
    logic                wr_valid;
    logic [RNID_W-1:0]   wr_rnid;
    logic [4:0]          wr_regidx;
  } lsu_issue_t;

  typedef struct packed {
    logic                  update;
    logic [MEM_Q_SIZE-1:0] index_oh;
    logic [CMT_ID_W-1:0]   cmt_id;
    logic                  except_valid;
    logic [VADDR_W-1:0]    vaddr;
    size_e                 size;
    logic                  st_data_valid;
    logic [XLEN_W-1:0]     st_data;
  } ex1_q_update_t;

  typedef struct packed {
    logic               valid;
    logic [VADDR_W-1:0] paddr;   // Line aligned
  } l1d_req_t;

  typedef struct packed {
    logic                           hit;
    logic [DCACHE_DATA_B_W*8-1:0]   data;
  } l1d_resp_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
    logic [VADDR_W-1:0]  paddr;
  } fwd_req_t;

  typedef struct packed {
    logic [XLEN_W/8-1:0] fwd_dw;
    logic [XLEN_W-1:0]   fwd_data;
  } fwd_resp_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rd_rnid;
    logic [XLEN_W-1:0] rd_data;
  } phy_wr_t;

endpackage

//--- lsu_pipe/lsu_decode.sv
`timescale 1ns/100ps

module lsu_decode
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  lsu_issue_t            i_rv0_issue,
  input  logic [MEM_Q_SIZE-1:0] i_rv0_index_oh,
  input  lsu_issue_t            i_replay_issue,
  input  logic [MEM_Q_SIZE-1:0] i_replay_index_oh,
  output logic                  o_rs_conflicted,
  output logic [MEM_Q_SIZE-1:0] o_rs_conf_index_oh,
  output lsu_issue_t            o_ex1_issue,
  output lsu_ctrl_t             o_ex1_ctrl,
  output logic [MEM_Q_SIZE-1:0] o_ex1_index_oh
);

  lsu_issue_t            r_ex0_issue;
  logic [MEM_Q_SIZE-1:0] r_ex0_index_oh;
  lsu_issue_t            w_ex0_sel;
  lsu_issue_t            w_ex0_issue;
  logic [MEM_Q_SIZE-1:0] w_ex0_index_oh;
  lsu_ctrl_t             w_ex0_ctrl;
  logic [6:0]            w_opcode;
  logic [2:0]            w_funct3;
  logic                  w_is_mem;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_issue    <= '0;
      r_ex0_index_oh <= '0;
    end else begin
      r_ex0_issue    <= i_rv0_issue;
      r_ex0_index_oh <= i_rv0_index_oh;
    end
  end

  // Replay wins over the registered issue
  assign w_ex0_sel      = i_replay_issue.valid ? i_replay_issue : r_ex0_issue;
  assign w_ex0_index_oh = i_replay_issue.valid ? i_replay_index_oh : '0;

  assign o_rs_conflicted    = i_replay_issue.valid & r_ex0_issue.valid;
  assign o_rs_conf_index_oh = r_ex0_index_oh;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  assign w_opcode = w_ex0_sel.inst[6:0];
  assign w_funct3 = w_ex0_sel.inst[14:12];
  assign w_is_mem = (w_opcode == OPCODE_LOAD) | (w_opcode == OPCODE_STORE);

  always_comb begin
    w_ex0_issue       = w_ex0_sel;
    w_ex0_issue.valid = w_ex0_sel.valid & w_is_mem;  // Non-memory opcodes dropped
  end

  assign w_ex0_ctrl.size = size_e'(w_funct3[1:0]);
  assign w_ex0_ctrl.sign = w_funct3[2] ? SIGN_U : SIGN_S;
  assign w_ex0_ctrl.op   = (w_opcode == OPCODE_STORE) ? OP_STORE : OP_LOAD;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex1_issue    <= '0;
      o_ex1_index_oh <= '0;
    end else begin
      o_ex1_issue    <= w_ex0_issue;
      o_ex1_index_oh <= w_ex0_index_oh;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex1_ctrl <= w_ex0_ctrl;
  end

  // A replay names exactly one queue entry
  assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_replay_issue.valid |-> $onehot(i_replay_index_oh));

endmodule

//--- lsu_pipe/lsu_execute.sv
`timescale 1ns/100ps

module lsu_execute
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  lsu_issue_t            i_ex1_issue,
  input  lsu_ctrl_t             i_ex1_ctrl,
  input  logic [MEM_Q_SIZE-1:0] i_ex1_index_oh,
  input  logic [XLEN_W-1:0]     i_rs1_data,
  input  logic [XLEN_W-1:0]     i_rs2_data,
  output logic [RNID_W-1:0]     o_rs1_rnid,
  output logic [RNID_W-1:0]     o_rs2_rnid,
  output l1d_req_t              o_l1d_req,
  output ex1_q_update_t         o_ex1_q_update,
  output lsu_issue_t            o_ex2_issue,
  output lsu_ctrl_t             o_ex2_ctrl,
  output logic [VADDR_W-1:0]    o_ex2_paddr,
  output logic                  o_ex2_except
);

  logic [31:0]        w_inst;
  logic               w_is_load;
  logic [VADDR_W-1:0] w_imm;
  logic [VADDR_W-1:0] w_base;
  logic [VADDR_W-1:0] w_vaddr;
  logic               w_misalign;

  // Register read
  assign o_rs1_rnid = i_ex1_issue.rs1_rnid;
  assign o_rs2_rnid = i_ex1_issue.rs2_rnid;

  // ----------------------------------------------------------
  // Address generation
  // ----------------------------------------------------------
  assign w_inst    = i_ex1_issue.inst;
  assign w_is_load = (i_ex1_ctrl.op == OP_LOAD);

  assign w_imm = w_is_load ?
                 {{(VADDR_W-12){w_inst[31]}}, w_inst[31:20]} :              // I-type
                 {{(VADDR_W-12){w_inst[31]}}, w_inst[31:25], w_inst[11:7]}; // S-type

  assign w_base  = i_ex1_issue.rs1_valid ? i_rs1_data[VADDR_W-1:0] : '0;
  assign w_vaddr = w_base + w_imm;

  always_comb begin
    unique case (i_ex1_ctrl.size)
      SIZE_B:  w_misalign = 1'b0;
      SIZE_H:  w_misalign = w_vaddr[0];
      SIZE_W:  w_misalign = |w_vaddr[1:0];
      SIZE_DW: w_misalign = |w_vaddr[2:0];
      default: w_misalign = 1'b0;
    endcase
  end

  // L1D read request, line aligned
  assign o_l1d_req.valid = i_ex1_issue.valid & w_is_load & !w_misalign;
  assign o_l1d_req.paddr = {w_vaddr[VADDR_W-1:L1D_OFS_W], {L1D_OFS_W{1'b0}}};

  // ----------------------------------------------------------
  // Memory queue update
  // ----------------------------------------------------------
  always_comb begin
    o_ex1_q_update.update        = i_ex1_issue.valid;
    o_ex1_q_update.index_oh      = i_ex1_index_oh;
    o_ex1_q_update.cmt_id        = i_ex1_issue.cmt_id;
    o_ex1_q_update.except_valid  = i_ex1_issue.valid & w_misalign;
    o_ex1_q_update.vaddr         = w_vaddr;
    o_ex1_q_update.size          = i_ex1_ctrl.size;
    o_ex1_q_update.st_data_valid = i_ex1_issue.rs2_valid & !w_is_load;
    o_ex1_q_update.st_data       = i_rs2_data;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2_issue  <= '0;
      o_ex2_except <= 1'b0;
    end else begin
      o_ex2_issue  <= i_ex1_issue;
      o_ex2_except <= i_ex1_issue.valid & w_misalign;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex2_ctrl  <= i_ex1_ctrl;
    o_ex2_paddr <= w_vaddr;  // No translation
  end

  assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ex1_q_update.update |-> $onehot0(o_ex1_q_update.index_oh));

endmodule

//--- lsu_pipe/lsu_result.sv
`timescale 1ns/100ps

module lsu_result
  import lsu_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  lsu_issue_t         i_ex2_issue,
  input  lsu_ctrl_t          i_ex2_ctrl,
  input  logic [VADDR_W-1:0] i_ex2_paddr,
  input  logic               i_ex2_except,
  input  l1d_resp_t          i_l1d_resp,
  input  fwd_resp_t          i_fwd_resp,
  output fwd_req_t           o_fwd_req,
  output logic               o_ex2_miss,
  output phy_wr_t            o_phy_wr
);

  logic                w_ld_valid;
  logic [DW_OFS_W-1:0] w_byte_ofs;
  logic [XLEN_W-1:0]   w_l1d_dw;
  logic [XLEN_W-1:0]   w_l1d_al;
  logic [XLEN_W/8-1:0] w_fwd_dw_al;
  logic [XLEN_W-1:0]   w_fwd_data_al;
  logic [XLEN_W-1:0]   w_merged;
  logic [XLEN_W/8-1:0] w_need_dw;
  logic                w_fwd_full;
  logic                w_miss;
  logic                w_signed;
  logic [XLEN_W-1:0]   w_ext;

  logic                r_ex3_valid;
  logic [RNID_W-1:0]   r_ex3_rnid;
  logic [XLEN_W-1:0]   r_ex3_data;

  assign w_ld_valid = i_ex2_issue.valid & (i_ex2_ctrl.op == OP_LOAD) & !i_ex2_except;
  assign w_byte_ofs = i_ex2_paddr[DW_OFS_W-1:0];

  // Store buffer lookup
  assign o_fwd_req.valid  = w_ld_valid;
  assign o_fwd_req.cmt_id = i_ex2_issue.cmt_id;
  assign o_fwd_req.paddr  = i_ex2_paddr;

  // ----------------------------------------------------------
  // Forward merge
  // ----------------------------------------------------------
  assign w_l1d_dw = i_l1d_resp.data[i_ex2_paddr[L1D_OFS_W-1:DW_OFS_W]*XLEN_W +: XLEN_W];
  assign w_l1d_al = w_l1d_dw >> {w_byte_ofs, 3'b000};

  assign w_fwd_dw_al   = i_fwd_resp.fwd_dw >> w_byte_ofs;
  assign w_fwd_data_al = i_fwd_resp.fwd_data >> {w_byte_ofs, 3'b000};

  always_comb begin
    for (int b = 0; b < XLEN_W / 8; b++) begin
      w_merged[b*8 +: 8] = w_fwd_dw_al[b] ? w_fwd_data_al[b*8 +: 8] : w_l1d_al[b*8 +: 8];
    end
  end

  // Bytes the access needs after alignment
  always_comb begin
    unique case (i_ex2_ctrl.size)
      SIZE_B:  w_need_dw = 8'h01;
      SIZE_H:  w_need_dw = 8'h03;
      SIZE_W:  w_need_dw = 8'h0f;
      SIZE_DW: w_need_dw = 8'hff;
      default: w_need_dw = 8'hff;
    endcase
  end

  assign w_fwd_full = &(w_fwd_dw_al | ~w_need_dw);
  assign w_miss     = w_ld_valid & !i_l1d_resp.hit & !w_fwd_full;
  assign o_ex2_miss = w_miss;

  // ----------------------------------------------------------
  // Extension and EX3 writeback
  // ----------------------------------------------------------
  assign w_signed = (i_ex2_ctrl.sign == SIGN_S);

  always_comb begin
    unique case (i_ex2_ctrl.size)
      SIZE_B:  w_ext = {{(XLEN_W-8){w_signed & w_merged[7]}}, w_merged[7:0]};
      SIZE_H:  w_ext = {{(XLEN_W-16){w_signed & w_merged[15]}}, w_merged[15:0]};
      SIZE_W:  w_ext = {{(XLEN_W-32){w_signed & w_merged[31]}}, w_merged[31:0]};
      default: w_ext = w_merged;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex3_valid <= w_ld_valid & !w_miss & i_ex2_issue.wr_valid &
                     (i_ex2_issue.wr_regidx != 5'd0);  // x0 never written
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_rnid <= i_ex2_issue.wr_rnid;
    r_ex3_data <= w_ext;
  end

  assign o_phy_wr.valid   = r_ex3_valid;
  assign o_phy_wr.rd_rnid = r_ex3_rnid;
  assign o_phy_wr.rd_data = r_ex3_data;

endmodule

//--- hdl/lsu_pipe_top.sv
`timescale 1ns/100ps

module lsu_pipe_top
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  lsu_issue_t            i_rv0_issue,
  input  logic [MEM_Q_SIZE-1:0] i_rv0_index_oh,
  input  lsu_issue_t            i_replay_issue,
  input  logic [MEM_Q_SIZE-1:0] i_replay_index_oh,
  output logic                  o_rs_conflicted,
  output logic [MEM_Q_SIZE-1:0] o_rs_conf_index_oh,

  output logic [RNID_W-1:0]     o_rs1_rnid,
  output logic [RNID_W-1:0]     o_rs2_rnid,
  input  logic [XLEN_W-1:0]     i_rs1_data,
  input  logic [XLEN_W-1:0]     i_rs2_data,

  output l1d_req_t              o_l1d_req,
  input  l1d_resp_t             i_l1d_resp,
  output fwd_req_t              o_fwd_req,
  input  fwd_resp_t             i_fwd_resp,

  output ex1_q_update_t         o_ex1_q_update,
  output logic                  o_ex2_miss,
  output phy_wr_t               o_phy_wr
);

  lsu_issue_t            w_ex1_issue;
  lsu_ctrl_t             w_ex1_ctrl;
  logic [MEM_Q_SIZE-1:0] w_ex1_index_oh;

  lsu_issue_t            w_ex2_issue;
  lsu_ctrl_t             w_ex2_ctrl;
  logic [VADDR_W-1:0]    w_ex2_paddr;
  logic                  w_ex2_except;

  lsu_decode lsu_decode_i (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_rv0_issue        (i_rv0_issue),
    .i_rv0_index_oh     (i_rv0_index_oh),
    .i_replay_issue     (i_replay_issue),
    .i_replay_index_oh  (i_replay_index_oh),
    .o_rs_conflicted    (o_rs_conflicted),
    .o_rs_conf_index_oh (o_rs_conf_index_oh),
    .o_ex1_issue        (w_ex1_issue),
    .o_ex1_ctrl         (w_ex1_ctrl),
    .o_ex1_index_oh     (w_ex1_index_oh)
  );

  lsu_execute lsu_execute_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex1_issue    (w_ex1_issue),
    .i_ex1_ctrl     (w_ex1_ctrl),
    .i_ex1_index_oh (w_ex1_index_oh),
    .i_rs1_data     (i_rs1_data),
    .i_rs2_data     (i_rs2_data),
    .o_rs1_rnid     (o_rs1_rnid),
    .o_rs2_rnid     (o_rs2_rnid),
    .o_l1d_req      (o_l1d_req),
    .o_ex1_q_update (o_ex1_q_update),
    .o_ex2_issue    (w_ex2_issue),
    .o_ex2_ctrl     (w_ex2_ctrl),
    .o_ex2_paddr    (w_ex2_paddr),
    .o_ex2_except   (w_ex2_except)
  );

  lsu_result lsu_result_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ex2_issue  (w_ex2_issue),
    .i_ex2_ctrl   (w_ex2_ctrl),
    .i_ex2_paddr  (w_ex2_paddr),
    .i_ex2_except (w_ex2_except),
    .i_l1d_resp   (i_l1d_resp),
    .i_fwd_resp   (i_fwd_resp),
    .o_fwd_req    (o_fwd_req),
    .o_ex2_miss   (o_ex2_miss),
    .o_phy_wr     (o_phy_wr)
  );

endmodule

//--- tests/lsu_tests.svh
`ifndef LSU_TESTS_SVH
`define LSU_TESTS_SVH

// ------------------------------------------------------------
// Helpers
// ------------------------------------------------------------
task automatic check_value(input string what, input logic [XLEN_W-1:0] got,
                           input logic [XLEN_W-1:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
  end
endtask

// Base register is rnid 3, store data comes from rnid 9
function automatic lsu_issue_t make_issue(input bit store, input logic [2:0] funct3,
                                          input logic [11:0] imm,
                                          input logic [RNID_W-1:0] wr_rnid,
                                          input logic [4:0] regidx);
  lsu_issue_t iss;
  iss = '0;
  iss.valid = 1'b1;
  if (store) begin
    iss.inst = {imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], OPCODE_STORE};
  end else begin
    iss.inst = {imm, 5'd1, funct3, regidx, OPCODE_LOAD};
  end
  iss.cmt_id    = 6'd7;
  iss.rs1_valid = 1'b1;
  iss.rs1_rnid  = 7'd3;
  iss.rs2_valid = store;
  iss.rs2_rnid  = 7'd9;
  iss.wr_valid  = !store;
  iss.wr_rnid   = wr_rnid;
  iss.wr_regidx = regidx;
  return iss;
endfunction

function automatic logic [VADDR_W-1:0] base_addr(input logic [11:0] imm);
  logic [XLEN_W-1:0] base;
  base = reg_value(7'd3);
  return base[VADDR_W-1:0] + {{(VADDR_W-12){imm[11]}}, imm};
endfunction

// Forwarded bytes win, other bytes follow the cache model
function automatic logic [XLEN_W-1:0] expected_load(input logic [VADDR_W-1:0] addr,
                                                    input int nbytes, input bit sext,
                                                    input logic [7:0] mask,
                                                    input logic [XLEN_W-1:0] fdata);
  logic [XLEN_W-1:0] val;
  int                ofs;
  val = '0;
  ofs = addr[2:0];
  for (int k = 0; k < nbytes; k++) begin
    if (mask[ofs+k]) val[k*8 +: 8] = fdata[(ofs+k)*8 +: 8];
    else val[k*8 +: 8] = 8'(addr[7:0] + k);
  end
  if (sext && val[nbytes*8-1]) begin
    for (int k = nbytes; k < 8; k++) val[k*8 +: 8] = 8'hff;
  end
  return val;
endfunction

task automatic set_models(input logic hit, input logic [7:0] mask,
                          input logic [XLEN_W-1:0] data);
  @(posedge i_clk);
  cache_hit <= hit;
  fwd_mask  <= mask;
  fwd_data  <= data;
endtask

task automatic send_issue(input lsu_issue_t iss, input logic [MEM_Q_SIZE-1:0] index_oh);
  @(posedge i_clk);
  i_rv0_issue    <= iss;
  i_rv0_index_oh <= index_oh;
  @(posedge i_clk);
  i_rv0_issue    <= '0;
  i_rv0_index_oh <= '0;
endtask

task automatic expect_write(input logic [RNID_W-1:0] rnid, input logic [XLEN_W-1:0] data,
                            input string what);
  int cycles;
  cycles = 0;
  @(negedge i_clk);
  while (!o_phy_wr.valid && cycles < 8) begin
    @(negedge i_clk);
    cycles++;
  end
  if (!o_phy_wr.valid) begin
    error_count++;
    $display("%s: no register write seen within 8 cycles", what);
  end else begin
    check_value({what, " rnid"}, o_phy_wr.rd_rnid, rnid);
    check_value({what, " data"}, o_phy_wr.rd_data, data);
  end
endtask

task automatic expect_no_write(input string what);
  for (int n = 0; n < 6; n++) begin
    @(negedge i_clk);
    if (o_phy_wr.valid) begin
      error_count++;
      $display("%s: unexpected register write at %0t ns", what, $time);
    end
  end
endtask

task automatic wait_q_update(output ex1_q_update_t upd, output logic l1d_valid);
  int cycles;
  cycles = 0;
  @(negedge i_clk);
  while (!o_ex1_q_update.update && cycles < 6) begin
    @(negedge i_clk);
    cycles++;
  end
  if (!o_ex1_q_update.update) begin
    error_count++;
    $display("no memory queue update seen within 6 cycles");
  end
  upd       = o_ex1_q_update;
  l1d_valid = o_l1d_req.valid;
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic test_hit_loads();
  logic [11:0]        imm;
  logic [VADDR_W-1:0] addr;
  int                 f;
  int                 nbytes;
  set_models(1'b1, 8'h00, '0);
  for (int n = 0; n < 14; n++) begin
    f      = n % 7;  // LB through LWU
    nbytes = 1 << f[1:0];
    imm    = 12'($random(seed)) & ~12'(nbytes - 1);
    addr   = base_addr(imm);
    send_issue(make_issue(1'b0, 3'(f), imm, 7'(20 + f), 5'd10), 8'h01);
    expect_write(7'(20 + f), expected_load(addr, nbytes, !f[2], 8'h00, '0), "hit load");
  end
endtask

task automatic test_store();
  ex1_q_update_t upd;
  logic          l1d_valid;
  logic [11:0]   imm;
  for (int f = 0; f < 4; f++) begin
    imm = 12'($random(seed)) & ~12'((1 << f) - 1);
    send_issue(make_issue(1'b1, 3'(f), imm, 7'd0, 5'd0), 8'h08);
    wait_q_update(upd, l1d_valid);
    check_value("store rs1 rnid", o_rs1_rnid, 7'd3);
    check_value("store rs2 rnid", o_rs2_rnid, 7'd9);
    check_value("store vaddr", upd.vaddr, base_addr(imm));
    check_value("store data", upd.st_data, reg_value(7'd9));
    check_value("store size", upd.size, f);
    check_value("store cmt_id", upd.cmt_id, 6'd7);
    check_value("store data valid", upd.st_data_valid, 1'b1);
    check_value("store exception", upd.except_valid, 1'b0);
    check_value("store queue index", upd.index_oh, '0);
    check_value("store cache request", l1d_valid, 1'b0);
    expect_no_write("store");
  end
endtask

task automatic test_partial_forward();
  logic [XLEN_W-1:0] data;
  logic [11:0]       imm;
  data = {$random(seed), $random(seed)};
  imm  = 12'($random(seed)) & 12'hff8;
  set_models(1'b1, 8'h5a, data);
  send_issue(make_issue(1'b0, 3'b011, imm, 7'd30, 5'd8), 8'h01);
  expect_write(7'd30, expected_load(base_addr(imm), 8, 1'b1, 8'h5a, data), "forward ld");
  imm = imm | 12'h004;  // Upper word of the doubleword
  set_models(1'b1, 8'h60, data);
  send_issue(make_issue(1'b0, 3'b010, imm, 7'd31, 5'd8), 8'h01);
  expect_write(7'd31, expected_load(base_addr(imm), 4, 1'b1, 8'h60, data), "forward lw");
endtask

task automatic test_miss();
  logic [XLEN_W-1:0] data;
  logic [11:0]       imm;
  int                cycles;
  data   = {$random(seed), $random(seed)};
  imm    = 12'($random(seed)) & 12'hffc;
  cycles = 0;
  set_models(1'b0, 8'h00, data);
  send_issue(make_issue(1'b0, 3'b010, imm, 7'd33, 5'd9), 8'h01);
  @(negedge i_clk);
  while (!o_ex2_miss && cycles < 6) begin
    @(negedge i_clk);
    cycles++;
  end
  if (!o_ex2_miss) begin
    error_count++;
    $display("missed load raised no miss strobe within 6 cycles");
  end
  check_value("miss forward valid", o_fwd_req.valid, 1'b1);
  check_value("miss forward cmt_id", o_fwd_req.cmt_id, 6'd7);
  check_value("miss forward paddr", o_fwd_req.paddr, base_addr(imm));
  expect_no_write("missed load");

  // Full forward covers the miss
  set_models(1'b0, 8'h0f << imm[2:0], data);
  send_issue(make_issue(1'b0, 3'b010, imm, 7'd34, 5'd9), 8'h01);
  expect_write(7'd34, expected_load(base_addr(imm), 4, 1'b1, 8'h0f << imm[2:0], data),
               "fully forwarded miss");
endtask

task automatic test_no_write();
  ex1_q_update_t upd;
  logic          l1d_valid;
  logic [11:0]   imm;
  imm = 12'($random(seed)) | 12'h001;
  set_models(1'b1, 8'h00, '0);
  send_issue(make_issue(1'b0, 3'b001, imm, 7'd35, 5'd4), 8'h01);
  wait_q_update(upd, l1d_valid);
  check_value("misaligned exception", upd.except_valid, 1'b1);
  check_value("misaligned vaddr", upd.vaddr, base_addr(imm));
  check_value("misaligned cache request", l1d_valid, 1'b0);
  expect_no_write("misaligned load");
  send_issue(make_issue(1'b0, 3'b011, 12'h040, 7'd36, 5'd0), 8'h01);
  expect_no_write("load to x0");
endtask

task automatic test_replay_conflict();
  set_models(1'b1, 8'h00, '0);
  send_issue(make_issue(1'b0, 3'b011, 12'h010, 7'd40, 5'd11), 8'h04);
  i_replay_issue    <= make_issue(1'b0, 3'b010, 12'h024, 7'd41, 5'd12);
  i_replay_index_oh <= 8'h20;
  @(negedge i_clk);
  check_value("conflict strobe", o_rs_conflicted, 1'b1);
  check_value("conflict index", o_rs_conf_index_oh, 8'h04);
  @(posedge i_clk);
  i_replay_issue    <= '0;
  i_replay_index_oh <= '0;
  @(negedge i_clk);
  check_value("replay queue index", o_ex1_q_update.index_oh, 8'h20);
  expect_write(7'd41, expected_load(base_addr(12'h024), 4, 1'b1, 8'h00, '0), "replay load");
  expect_no_write("dropped issue");
endtask

`endif

//--- tests/tb_lsu_pipe.sv
`timescale 1ns/100ps

module tb_lsu_pipe
  import lsu_pkg::*;
();

  logic                  i_clk;
  logic                  i_reset_n;
  lsu_issue_t            i_rv0_issue;
  logic [MEM_Q_SIZE-1:0] i_rv0_index_oh;
  lsu_issue_t            i_replay_issue;
  logic [MEM_Q_SIZE-1:0] i_replay_index_oh;
  logic                  o_rs_conflicted;
  logic [MEM_Q_SIZE-1:0] o_rs_conf_index_oh;
  logic [RNID_W-1:0]     o_rs1_rnid;
  logic [RNID_W-1:0]     o_rs2_rnid;
  logic [XLEN_W-1:0]     i_rs1_data;
  logic [XLEN_W-1:0]     i_rs2_data;
  l1d_req_t              o_l1d_req;
  l1d_resp_t             i_l1d_resp;
  fwd_req_t              o_fwd_req;
  fwd_resp_t             i_fwd_resp;
  ex1_q_update_t         o_ex1_q_update;
  logic                  o_ex2_miss;
  phy_wr_t               o_phy_wr;

  // Memory model controls, set per test
  logic                  cache_hit;
  logic [7:0]            fwd_mask;
  logic [XLEN_W-1:0]     fwd_data;
  int                    error_count;
  int                    check_count;
  integer                seed;

  lsu_pipe_top lsu_pipe_top_i (.*);

  always #4 i_clk = ~i_clk;

  // ------------------------------------------------------------
  // Register, cache and store buffer models
  // ------------------------------------------------------------
  function automatic logic [XLEN_W-1:0] reg_value(input logic [RNID_W-1:0] rnid);
    return XLEN_W'(rnid) * 64'h1000 + 64'h100;
  endfunction

  assign i_rs1_data = reg_value(o_rs1_rnid);
  assign i_rs2_data = reg_value(o_rs2_rnid);

  // Line byte i of address A reads as A[7:0] + i
  always @(posedge i_clk) begin
    i_l1d_resp.hit <= o_l1d_req.valid & cache_hit;
    for (int i = 0; i < DCACHE_DATA_B_W; i++) begin
      i_l1d_resp.data[i*8 +: 8] <= 8'(o_l1d_req.paddr[7:0] + i);
    end
  end

  assign i_fwd_resp.fwd_dw   = o_fwd_req.valid ? fwd_mask : 8'h00;  // Same cycle as request
  assign i_fwd_resp.fwd_data = fwd_data;

  `include "lsu_tests.svh"

  initial begin
    seed              = 27985;
    error_count       = 0;
    check_count       = 0;
    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_rv0_issue       = '0;
    i_rv0_index_oh    = '0;
    i_replay_issue    = '0;
    i_replay_index_oh = '0;
    i_l1d_resp        = '0;
    cache_hit         = 1'b1;
    fwd_mask          = 8'h00;
    fwd_data          = '0;
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    repeat (2) @(posedge i_clk);

    test_hit_loads();
    test_store();
    test_partial_forward();
    test_miss();
    test_no_write();
    test_replay_conflict();

    repeat (4) @(posedge i_clk);
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- lsu_pipe.f
+incdir+tests
common/lsu_pkg.sv
lsu_pipe/lsu_decode.sv
lsu_pipe/lsu_execute.sv
lsu_pipe/lsu_result.sv
hdl/lsu_pipe_top.sv
tests/tb_lsu_pipe.sv

//--- Bender.yml
package:
  name: lsu_pipe

sources:
  - common/lsu_pkg.sv
  - lsu_pipe/lsu_decode.sv
  - lsu_pipe/lsu_execute.sv
  - lsu_pipe/lsu_result.sv
  - hdl/lsu_pipe_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_lsu_pipe.sv
